/* rtl/char_classifier.sv */
module char_classifier (
    input  logic [7:0]                    char,
    output trace_format_pkg::char_class_t char_class
);

    always_comb begin
        char_class.is_dec      = 1'b0;
        char_class.is_hex      = 1'b0;
        char_class.digit_value = 4'd0;

        // ASCII digits carry their value in the low nibble
        if (char >= "0" && char <= "9") begin
            char_class.is_dec      = 1'b1;
            char_class.is_hex      = 1'b1;
            char_class.digit_value = char[3:0];
        end else if (char >= "a" && char <= "f") begin
            // 'a' is 0x61, so low nibble plus nine
            char_class.is_hex      = 1'b1;
            char_class.digit_value = char[3:0] + 4'd9;
        end

        case (char)
            "^":     char_class.sym = trace_format_pkg::caret;
            "@":     char_class.sym = trace_format_pkg::at;
            ":":     char_class.sym = trace_format_pkg::colon;
            " ":     char_class.sym = trace_format_pkg::space;
            "$":     char_class.sym = trace_format_pkg::dollar;
            "*":     char_class.sym = trace_format_pkg::star;
            "<":     char_class.sym = trace_format_pkg::less;
            "=":     char_class.sym = trace_format_pkg::equal;
            "#":     char_class.sym = trace_format_pkg::hash;
            default: char_class.sym = trace_format_pkg::other;
        endcase
    end

endmodule

/* rtl/digit_counter.sv */
module digit_counter (
    input  logic clk,
    input  logic reset,
    input  logic count_clear,
    input  logic count_step,
    output logic dec_room,
    output logic dec_ok,
    output logic hex_full
);

    logic [trace_parse_pkg::COUNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset || count_clear) begin
            count <= '0;
        end else if (count_step) begin
            count <= count + 1'b1;
        end
    end

    // Limit flags so the FSM never looks at the raw count
    assign dec_room = count < trace_parse_pkg::COUNT_W'(trace_parse_pkg::DEC_MAX);
    assign dec_ok   = (count != '0) &&
                      (count <= trace_parse_pkg::COUNT_W'(trace_parse_pkg::DEC_MAX));
    assign hex_full = count == trace_parse_pkg::COUNT_W'(trace_parse_pkg::HEX_LEN);

endmodule

/* rtl/field_accumulator.sv */
module field_accumulator (
    input  logic                            clk,
    input  logic                            reset,
    input  trace_format_pkg::char_class_t   char_class,
    input  trace_parse_pkg::field_cmd_t     cmd,
    output trace_format_pkg::trace_record_t record
);

    localparam int W = trace_format_pkg::VALUE_W;

    trace_format_pkg::format_t kind_q;
    logic [W-1:0]              time_q;
    logic [W-1:0]              pc_q;
    logic [W-1:0]              slot_q;
    logic [W-1:0]              data_q;
    logic [W-1:0]              cur_value;
    logic [W-1:0]              next_value;
    logic [W-1:0]              digit;
    logic                      is_decimal;

    assign digit = W'(char_class.digit_value);

    // Time is always decimal, slot only for register writes
    assign is_decimal = (cmd.field == trace_parse_pkg::time_f) ||
                        (cmd.field == trace_parse_pkg::slot_f &&
                         kind_q == trace_format_pkg::reg_write);

    always_comb begin
        case (cmd.field)
            trace_parse_pkg::time_f: cur_value = time_q;
            trace_parse_pkg::pc_f:   cur_value = pc_q;
            trace_parse_pkg::slot_f: cur_value = slot_q;
            default:                 cur_value = data_q;
        endcase

        if (cmd.start) begin
            next_value = digit;
        end else if (is_decimal) begin
            // Times ten as x8 plus x2
            next_value = (cur_value << 3) + (cur_value << 1) + digit;
        end else begin
            next_value = {cur_value[W-5:0], char_class.digit_value};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            kind_q <= trace_format_pkg::none;
        end else if (cmd.kind != trace_format_pkg::none) begin
            kind_q <= cmd.kind;
        end
    end

    // Field payload
    always_ff @(posedge clk) begin
        if (cmd.start || cmd.shift) begin
            case (cmd.field)
                trace_parse_pkg::time_f: time_q <= next_value;
                trace_parse_pkg::pc_f:   pc_q   <= next_value;
                trace_parse_pkg::slot_f: slot_q <= next_value;
                default:                 data_q <= next_value;
            endcase
        end
    end

    assign record = '{kind: kind_q, time_val: time_q, pc: pc_q, slot: slot_q, data: data_q};

endmodule

/* rtl/trace_checker.sv */
module trace_checker (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [7:0]                      char,
    output trace_format_pkg::format_t       format_type,
    output trace_format_pkg::trace_record_t record
);

    trace_format_pkg::char_class_t char_class;
    trace_parse_pkg::field_cmd_t   cmd;
    logic                          count_clear;
    logic                          count_step;
    logic                          dec_room;
    logic                          dec_ok;
    logic                          hex_full;

    char_classifier u_classifier (
        .char       (char),
        .char_class (char_class)
    );

    digit_counter u_counter (
        .clk         (clk),
        .reset       (reset),
        .count_clear (count_clear),
        .count_step  (count_step),
        .dec_room    (dec_room),
        .dec_ok      (dec_ok),
        .hex_full    (hex_full)
    );

    field_accumulator u_accumulator (
        .clk        (clk),
        .reset      (reset),
        .char_class (char_class),
        .cmd        (cmd),
        .record     (record)
    );

    trace_parser_fsm u_fsm (
        .clk         (clk),
        .reset       (reset),
        .char_class  (char_class),
        .dec_room    (dec_room),
        .dec_ok      (dec_ok),
        .hex_full    (hex_full),
        .count_clear (count_clear),
        .count_step  (count_step),
        .cmd         (cmd),
        .format_type (format_type)
    );

endmodule

/* rtl/trace_format_pkg.sv */
package trace_format_pkg;

    ////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////

    localparam int VALUE_W = 32;

    ////////////////////////////////////////////////////////////
    // Character and record formats
    ////////////////////////////////////////////////////////////

    // Punctuation that matters to the trace grammar
    typedef enum logic [3:0] {
        caret, at, colon, space, dollar, star, less, equal, hash, other
    } sym_t;

    typedef struct packed {
        logic       is_dec;
        logic       is_hex;
        logic [3:0] digit_value;
        sym_t       sym;
    } char_class_t;

    typedef enum logic [1:0] {
        none      = 2'd0,
        reg_write = 2'd1,
        mem_write = 2'd2
    } format_t;

    // Slot holds grf for a register write and addr for a memory write
    typedef struct packed {
        format_t              kind;
        logic [VALUE_W-1:0]   time_val;
        logic [VALUE_W-1:0]   pc;
        logic [VALUE_W-1:0]   slot;
        logic [VALUE_W-1:0]   data;
    } trace_record_t;

endpackage

/* rtl/trace_parse_pkg.sv */
package trace_parse_pkg;

    // Digit limits per field
    localparam int DEC_MAX = 4;
    localparam int HEX_LEN = 8;
    localparam int COUNT_W = 4;

    typedef enum logic [4:0] {
        idle,
        time_digits,
        pc_first, pc_digits,
        colon_spaces,
        grf_first, grf_digits, grf_spaces,
        addr_first, addr_digits, addr_spaces,
        less_seen,
        data_spaces, data_digits,
        done
    } parse_state_t;

    typedef enum logic [1:0] {
        time_f, pc_f, slot_f, data_f
    } field_t;

    // Control to datapath, one per character
    typedef struct packed {
        logic                      start;
        logic                      shift;
        field_t                    field;
        trace_format_pkg::format_t kind;
    } field_cmd_t;

endpackage

/* rtl/trace_parser_fsm.sv */
module trace_parser_fsm (
    input  logic                          clk,
    input  logic                          reset,
    input  trace_format_pkg::char_class_t char_class,
    input  logic                          dec_room,
    input  logic                          dec_ok,
    input  logic                          hex_full,
    output logic                          count_clear,
    output logic                          count_step,
    output trace_parse_pkg::field_cmd_t   cmd,
    output trace_format_pkg::format_t     format_type
);

    trace_parse_pkg::parse_state_t state;
    trace_parse_pkg::parse_state_t state_next;
    trace_format_pkg::format_t     kind_q;
    trace_format_pkg::format_t     kind_next;
    trace_format_pkg::sym_t        sym;

    assign sym = char_class.sym;

    // Count runs only across accepted digits
    assign count_clear = !count_step;

    ////////////////////////////////////////////////////////////
    // Next state and datapath commands
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = trace_parse_pkg::idle;
        kind_next  = kind_q;
        count_step = 1'b0;
        cmd        = '{start: 1'b0, shift: 1'b0, field: trace_parse_pkg::time_f,
                       kind: trace_format_pkg::none};

        case (state)
            trace_parse_pkg::idle: begin
                if (sym == trace_format_pkg::caret) state_next = trace_parse_pkg::time_digits;
            end
            trace_parse_pkg::time_digits: begin
                // dec_ok low means no digit yet
                if (char_class.is_dec && dec_room) begin
                    state_next = trace_parse_pkg::time_digits;
                    count_step = 1'b1;
                    cmd.start  = !dec_ok;
                    cmd.shift  = dec_ok;
                end else if (sym == trace_format_pkg::at && dec_ok) begin
                    state_next = trace_parse_pkg::pc_first;
                end
            end
            trace_parse_pkg::pc_first, trace_parse_pkg::pc_digits: begin
                cmd.field = trace_parse_pkg::pc_f;
                if (char_class.is_hex && !hex_full) begin
                    state_next = trace_parse_pkg::pc_digits;
                    count_step = 1'b1;
                    cmd.start  = state == trace_parse_pkg::pc_first;
                    cmd.shift  = state == trace_parse_pkg::pc_digits;
                end else if (sym == trace_format_pkg::colon && hex_full) begin
                    state_next = trace_parse_pkg::colon_spaces;
                end
            end
            trace_parse_pkg::colon_spaces: begin
                if (sym == trace_format_pkg::space) begin
                    state_next = trace_parse_pkg::colon_spaces;
                end else if (sym == trace_format_pkg::dollar) begin
                    state_next = trace_parse_pkg::grf_first;
                    kind_next  = trace_format_pkg::reg_write;
                    cmd.kind   = trace_format_pkg::reg_write;
                end else if (sym == trace_format_pkg::star) begin
                    state_next = trace_parse_pkg::addr_first;
                    kind_next  = trace_format_pkg::mem_write;
                    cmd.kind   = trace_format_pkg::mem_write;
                end
            end
            trace_parse_pkg::grf_first, trace_parse_pkg::grf_digits: begin
                cmd.field = trace_parse_pkg::slot_f;
                if (char_class.is_dec && dec_room) begin
                    state_next = trace_parse_pkg::grf_digits;
                    count_step = 1'b1;
                    cmd.start  = state == trace_parse_pkg::grf_first;
                    cmd.shift  = state == trace_parse_pkg::grf_digits;
                end else if (sym == trace_format_pkg::space && dec_ok) begin
                    state_next = trace_parse_pkg::grf_spaces;
                end else if (sym == trace_format_pkg::less && dec_ok) begin
                    state_next = trace_parse_pkg::less_seen;
                end
            end
            trace_parse_pkg::addr_first, trace_parse_pkg::addr_digits: begin
                cmd.field = trace_parse_pkg::slot_f;
                if (char_class.is_hex && !hex_full) begin
                    state_next = trace_parse_pkg::addr_digits;
                    count_step = 1'b1;
                    cmd.start  = state == trace_parse_pkg::addr_first;
                    cmd.shift  = state == trace_parse_pkg::addr_digits;
                end else if (sym == trace_format_pkg::space && hex_full) begin
                    state_next = trace_parse_pkg::addr_spaces;
                end else if (sym == trace_format_pkg::less && hex_full) begin
                    state_next = trace_parse_pkg::less_seen;
                end
            end
            trace_parse_pkg::grf_spaces, trace_parse_pkg::addr_spaces: begin
                if (sym == trace_format_pkg::space) state_next = state;
                else if (sym == trace_format_pkg::less) state_next = trace_parse_pkg::less_seen;
            end
            trace_parse_pkg::less_seen: begin
                // "<" needs "=" right behind it
                if (sym == trace_format_pkg::equal) state_next = trace_parse_pkg::data_spaces;
            end
            trace_parse_pkg::data_spaces, trace_parse_pkg::data_digits: begin
                cmd.field = trace_parse_pkg::data_f;
                if (state == trace_parse_pkg::data_spaces && sym == trace_format_pkg::space) begin
                    state_next = trace_parse_pkg::data_spaces;
                end else if (char_class.is_hex && !hex_full) begin
                    state_next = trace_parse_pkg::data_digits;
                    count_step = 1'b1;
                    cmd.start  = state == trace_parse_pkg::data_spaces;
                    cmd.shift  = state == trace_parse_pkg::data_digits;
                end else if (state == trace_parse_pkg::data_digits &&
                             sym == trace_format_pkg::hash && hex_full) begin
                    state_next = trace_parse_pkg::done;
                end
            end
            trace_parse_pkg::done: begin
                // Back to back records
                if (sym == trace_format_pkg::caret) state_next = trace_parse_pkg::time_digits;
            end
            default: state_next = trace_parse_pkg::idle;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // State, kind and format code
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= trace_parse_pkg::idle;
            kind_q      <= trace_format_pkg::none;
            format_type <= trace_format_pkg::none;
        end else begin
            state  <= state_next;
            kind_q <= kind_next;
            // Code is up only for the cycle spent in done
            format_type <= (state_next == trace_parse_pkg::done) ? kind_q :
                                                                   trace_format_pkg::none;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the trace checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module trace_checker_tb -f trace_checker.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/Vtrace_checker_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

/* sim/trace_checker_monitor.sv */
module trace_checker_monitor (
    input  logic                            clk,
    input  logic                            reset,
    input  trace_format_pkg::format_t       format_type,
    input  trace_format_pkg::trace_record_t record,
    input  logic                            exp_valid,
    input  trace_format_pkg::trace_record_t exp_record,
    input  logic                            test_end,
    input  int                              test_num,
    output int                              errors,
    output int                              tests_failed
);

    timeunit 1ns;
    timeprecision 1ps;

    int test_errors;
    int records_seen;

    initial begin
        errors = 0;
        tests_failed = 0;
        test_errors = 0;
        records_seen = 0;
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset && exp_valid) begin
            records_seen++;
            if (format_type !== exp_record.kind) begin
                $display("Mismatch at %0t: format_type got %0d expected %0d",
                         $time, format_type, exp_record.kind);
                test_errors++;
            end
            if (record.kind !== exp_record.kind) begin
                $display("Mismatch at %0t: record.kind got %0d expected %0d",
                         $time, record.kind, exp_record.kind);
                test_errors++;
            end
            compare_field("record.time_val", record.time_val, exp_record.time_val);
            compare_field("record.pc", record.pc, exp_record.pc);
            compare_field("record.slot", record.slot, exp_record.slot);
            compare_field("record.data", record.data, exp_record.data);
        end else if (!reset && format_type !== trace_format_pkg::none) begin
            $display("Error at %0t: format code %0d raised where no record was complete",
                     $time, format_type);
            test_errors++;
        end

        if (test_end) begin
            $display("Test %0d finished: %0d records checked, %0d errors",
                     test_num, records_seen, test_errors);
            if (test_errors != 0) tests_failed++;
            errors += test_errors;
            test_errors = 0;
            records_seen = 0;
        end
    end

endmodule

/* sim/trace_checker_sva.sv */
module trace_checker_sva (
    input logic                          clk,
    input logic                          reset,
    input trace_format_pkg::char_class_t char_class,
    input trace_format_pkg::format_t     format_type
);

    timeunit 1ns;
    timeprecision 1ps;

    // Quiet during reset and the first cycle after it
    reset_clears_code: assert property (@(posedge clk)
        reset |=> format_type == trace_format_pkg::none ##1
                  format_type == trace_format_pkg::none)
        else $error("format_type nonzero during or right after reset");

    code_one_cycle: assert property (@(posedge clk) disable iff (reset)
        format_type != trace_format_pkg::none |=> format_type == trace_format_pkg::none)
        else $error("format_type held for more than one cycle");

    code_after_hash: assert property (@(posedge clk) disable iff (reset)
        format_type != trace_format_pkg::none |-> $past(char_class.sym) == trace_format_pkg::hash)
        else $error("format_type raised without a closing hash");

endmodule

bind trace_parser_fsm trace_checker_sva sva_i (
    .clk         (clk),
    .reset       (reset),
    .char_class  (char_class),
    .format_type (format_type)
);

/* sim/trace_checker_tb.sv */
module trace_checker_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                            clk;
    logic                            reset;
    logic [7:0]                      char;
    trace_format_pkg::format_t       format_type;
    trace_format_pkg::trace_record_t record;
    logic                            exp_valid;
    trace_format_pkg::trace_record_t exp_record;
    logic                            test_end;
    int                              test_num;
    int                              errors;
    int                              tests_failed;

    int unsigned                     lcg_state = 56282;
    string                           lines[$];
    int                              line_test[$];
    bit                              line_reset[$];
    bit                              exp_hit[$];
    trace_format_pkg::trace_record_t exp_rec[$];
    bit                              pending;
    trace_format_pkg::trace_record_t pending_rec;
    int                              total_cycles = 0;
    int                              cycle_count = 0;
    int                              cycle_limit = 0;

    trace_checker trace_checker_i (
        .clk         (clk),
        .reset       (reset),
        .char        (char),
        .format_type (format_type),
        .record      (record)
    );

    trace_checker_monitor monitor_i (
        .clk          (clk),
        .reset        (reset),
        .format_type  (format_type),
        .record       (record),
        .exp_valid    (exp_valid),
        .exp_record   (exp_record),
        .test_end     (test_end),
        .test_num     (test_num),
        .errors       (errors),
        .tests_failed (tests_failed)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: run did not end within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Line generator
    ////////////////////////////////////////////////////////////

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    function automatic int pick(int n);
        return int'(lcg_next() % n);
    endfunction

    function automatic string digits(int n, bit hex);
        string set;
        string s;
        int    k;
        set = "0123456789abcdef";
        s = "";
        for (int i = 0; i < n; i++) begin
            k = hex ? pick(16) : pick(10);
            s = {s, set.substr(k, k)};
        end
        return s;
    endfunction

    function automatic string spaces(int n);
        string s;
        s = "";
        for (int i = 0; i < n; i++) s = {s, " "};
        return s;
    endfunction

    function automatic string noise_line(int n);
        string set;
        string s;
        int    k;
        set = " ^#@$*<=:xA09f";
        s = "";
        for (int i = 0; i < n; i++) begin
            k = pick(14);
            s = {s, set.substr(k, k)};
        end
        return s;
    endfunction

    function automatic string build_line(bit mem, int tdig, int pcdig, bit lt_ok, bit upper,
                                         bit colon);
        string pc;
        string col;
        string kch;
        string slot;
        string lt;
        pc = digits(pcdig, 1);
        // Uppercase letters are outside the trace alphabet
        if (upper) pc = {"A", pc.substr(1, pc.len() - 1)};
        col = "";
        if (colon) col = ":";
        lt = "<=";
        if (!lt_ok) lt = "<-";
        kch = "$";
        slot = digits(1 + pick(4), 0);
        if (mem) begin
            kch = "*";
            slot = digits(8, 1);
        end
        return {"^", digits(tdig, 0), "@", pc, col, spaces(pick(3)), kch, slot,
                spaces(pick(3)), lt, spaces(pick(3)), digits(8, 1), "#"};
    endfunction

    function automatic string valid_line(bit mem);
        return build_line(mem, 1 + pick(4), 8, 1, 0, 1);
    endfunction

    function automatic void add_line(string s, int test, bit rst);
        lines.push_back(s);
        line_test.push_back(test);
        line_reset.push_back(rst);
        total_cycles += s.len() + 1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model of the trace grammar
    ////////////////////////////////////////////////////////////

    function automatic void check_line(string line);
        int                              st;
        int                              n;
        logic [7:0]                      c;
        logic [7:0]                      v;
        bit                              dec;
        bit                              hex;
        bit                              hit;
        trace_format_pkg::trace_record_t r;
        st = 0;
        n = 0;
        r = '0;
        exp_hit.delete();
        exp_rec.delete();
        for (int i = 0; i < line.len(); i++) begin
            c = line[i];
            dec = c >= "0" && c <= "9";
            hex = dec || (c >= "a" && c <= "f");
            v = dec ? c - 8'h30 : c - 8'h57;
            hit = 0;
            case (st)
                1: if (dec && n < 4) begin
                    r.time_val = r.time_val * 10 + v;
                    n++;
                end else if (c == "@" && n > 0) begin
                    st = 2;
                    n = 0;
                    r.pc = 0;
                end else st = 0;
                2: if (hex && n < 8) begin
                    r.pc = {r.pc[27:0], v[3:0]};
                    n++;
                end else if (c == ":" && n == 8) st = 3;
                else st = 0;
                3: if (c == "$" || c == "*") begin
                    r.kind = (c == "$") ? trace_format_pkg::reg_write : trace_format_pkg::mem_write;
                    st = 4;
                    n = 0;
                    r.slot = 0;
                end else if (c != " ") st = 0;
                4: if (r.kind == trace_format_pkg::reg_write && dec && n < 4) begin
                    r.slot = r.slot * 10 + v;
                    n++;
                end else if (r.kind == trace_format_pkg::mem_write && hex && n < 8) begin
                    r.slot = {r.slot[27:0], v[3:0]};
                    n++;
                end else if ((c == " " || c == "<") &&
                             (r.kind == trace_format_pkg::reg_write ? n > 0 : n == 8)) begin
                    st = (c == " ") ? 5 : 6;
                end else st = 0;
                5: if (c == "<") st = 6;
                else if (c != " ") st = 0;
                6: if (c == "=") begin
                    st = 7;
                    n = 0;
                    r.data = 0;
                end else st = 0;
                7: if (hex && n < 8) begin
                    r.data = {r.data[27:0], v[3:0]};
                    n++;
                end else if (c == "#" && n == 8) begin
                    st = 8;
                    hit = 1;
                end else if (!(c == " " && n == 0)) st = 0;
                // Idle and done both open a record on a caret
                default: if (c == "^") begin
                    st = 1;
                    n = 0;
                    r.time_val = 0;
                end else st = 0;
            endcase
            exp_hit.push_back(hit);
            exp_rec.push_back(r);
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////

    task automatic drive_char(input logic [7:0] c);
        @(posedge clk);
        #1;
        char = c;
        test_end = 0;
        exp_valid = pending;
        exp_record = pending_rec;
        pending = 0;
    endtask

    task automatic send_line(input int idx);
        string s;
        int    cut;
        s = lines[idx];
        // A reset line is broken off after its first characters
        cut = line_reset[idx] ? 15 : s.len();
        check_line(s.substr(0, cut - 1));
        for (int i = 0; i < cut; i++) begin
            drive_char(s[i]);
            pending = exp_hit[i];
            pending_rec = exp_rec[i];
        end
        if (cut < s.len()) begin
            // One reset cycle, then the rest of the line runs from idle
            s = s.substr(cut, s.len() - 1);
            check_line(s);
            reset = 1;
            for (int i = 0; i < s.len(); i++) begin
                drive_char(s[i]);
                reset = 0;
                pending = exp_hit[i];
                pending_rec = exp_rec[i];
            end
        end
        drive_char(8'h0a);
    endtask

    task automatic finish_test(input int num);
        drive_char(8'h0a);
        drive_char(8'h0a);
        test_num = num;
        test_end = 1;
    endtask

    initial begin
        clk = 0;
        reset = 1;
        char = 8'h0a;
        exp_valid = 0;
        exp_record = '0;
        test_end = 0;
        test_num = 0;
        pending = 0;
        pending_rec = '0;

        for (int i = 0; i < 8; i++) add_line(build_line(0, 1 + i % 4, 8, 1, 0, 1), 1, 0);
        for (int i = 0; i < 8; i++) add_line(valid_line(1), 2, 0);
        add_line(build_line(0, 5, 8, 1, 0, 1), 3, 0);
        add_line(valid_line(0), 3, 0);
        add_line(build_line(1, 2, 7, 1, 0, 1), 3, 0);
        add_line(valid_line(1), 3, 0);
        add_line(build_line(0, 3, 9, 1, 0, 1), 3, 0);
        add_line(valid_line(0), 3, 0);
        add_line(build_line(1, 1, 8, 0, 0, 1), 3, 0);
        add_line(valid_line(1), 3, 0);
        add_line(build_line(0, 2, 8, 1, 1, 1), 3, 0);
        add_line(valid_line(0), 3, 0);
        add_line(build_line(1, 4, 8, 1, 0, 0), 3, 0);
        add_line(valid_line(1), 3, 0);
        for (int i = 0; i < 3; i++) begin
            add_line({valid_line(pick(2)), valid_line(pick(2)), valid_line(pick(2))}, 4, 0);
        end
        add_line(valid_line(0), 5, 1);
        add_line(valid_line(1), 5, 0);
        for (int i = 0; i < 40; i++) begin
            case (pick(4))
                0: add_line(valid_line(0), 6, 0);
                1: add_line(valid_line(1), 6, 0);
                2: add_line(build_line(pick(2), 1 + pick(5), 7 + pick(3), pick(4) != 0,
                                       pick(4) == 0, pick(4) != 0), 6, 0);
                default: add_line(noise_line(5 + pick(20)), 6, 0);
            endcase
        end
        cycle_limit = total_cycles + 6 * 2 + 8 + 100;

        repeat (8) @(posedge clk);
        #1;
        reset = 0;
        for (int idx = 0; idx < lines.size(); idx++) begin
            if (idx > 0 && line_test[idx] != line_test[idx - 1]) finish_test(line_test[idx - 1]);
            send_line(idx);
        end
        finish_test(line_test[lines.size() - 1]);
        drive_char(8'h0a);
        @(posedge clk);
        #1;
        $display("Summary: 6 tests, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* trace_checker.f */
rtl/trace_format_pkg.sv
rtl/trace_parse_pkg.sv
rtl/char_classifier.sv
rtl/digit_counter.sv
rtl/field_accumulator.sv
rtl/trace_parser_fsm.sv
rtl/trace_checker.sv
sim/trace_checker_sva.sv
sim/trace_checker_monitor.sv
sim/trace_checker_tb.sv
